// File: gcn_agg.f
+incdir+src
src/gcn_pkg.sv
src/gcn_wb_regs.sv
src/gcn_adj_builder.sv
src/gcn_node_agg.sv
src/gcn_top.sv
verif/gcn_clk_gen.sv
verif/gcn_chk.sv
verif/gcn_tb.sv

// File: src/gcn_adj_builder.sv
`include "gcn_settings.svh"

module gcn_adj_builder
    import gcn_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  node_id_t   edge_src [`GCN_EDGES],
    input  node_id_t   edge_dst [`GCN_EDGES],
    output node_mask_t adj_rows [`GCN_NODES],
    output logic       clear,
    output logic       capture,
    output logic       busy
);

    localparam int cnt_w = $clog2(`GCN_EDGES);

    adj_state_t       state_r;
    adj_state_t       state;        // start folds into the clear cycle
    adj_state_t       state_nxt;
    logic [cnt_w-1:0] edge_cnt;
    logic             last_edge;
    node_mask_t       src_bit;
    node_mask_t       dst_bit;

    // ids outside 1..GCN_NODES give an empty mask
    function automatic node_mask_t id_to_bit(node_id_t id);
        node_mask_t m;
        m = '0;
        for (int n = 0; n < `GCN_NODES; n++) begin
            if (id == node_id_t'(n + 1))
                m[n] = 1'b1;
        end
        return m;
    endfunction

    ///////////////////////////////
    // edge walker FSM
    ///////////////////////////////
    always_comb begin
        state = state_r;
        if (state_r == st_idle && start)
            state = st_clear;
    end

    assign last_edge = (edge_cnt == cnt_w'(`GCN_EDGES - 1));

    always_comb begin
        state_nxt = st_idle;
        case (state)
            st_clear:   state_nxt = st_walk;
            st_walk:    state_nxt = last_edge ? st_capture : st_walk;
            default:    state_nxt = st_idle;    // capture and idle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_r  <= st_idle;
            edge_cnt <= '0;
        end else begin
            state_r <= state_nxt;
            if (state == st_walk)
                edge_cnt <= last_edge ? '0 : edge_cnt + 1'b1;  // back at 0 for the next run
        end
    end

    assign clear   = (state == st_clear);
    assign capture = (state == st_capture);
    assign busy    = (state != st_idle);

    ///////////////////////////////
    // symmetric matrix fill
    ///////////////////////////////

    // an empty mask at either end leaves every row as it is
    assign src_bit = id_to_bit(edge_src[edge_cnt]);
    assign dst_bit = id_to_bit(edge_dst[edge_cnt]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < `GCN_NODES; n++)
                adj_rows[n] <= '0;
        end else if (clear) begin
            for (int n = 0; n < `GCN_NODES; n++)
                adj_rows[n] <= '0;
        end else if (state == st_walk) begin
            // OR keeps duplicate edges harmless
            for (int n = 0; n < `GCN_NODES; n++)
                adj_rows[n] <= adj_rows[n] | (src_bit[n] ? dst_bit : '0)
                                           | (dst_bit[n] ? src_bit : '0);
        end
    end

endmodule

// File: src/gcn_node_agg.sv
`include "gcn_settings.svh"

module gcn_node_agg
    import gcn_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       capture,
    input  node_mask_t adj_row,
    input  feat_t      feats [`GCN_NODES][`GCN_FEAT_COLS],
    output agg_sum_t   sums [`GCN_FEAT_COLS]
);

    agg_sum_t acc [`GCN_FEAT_COLS];

    // masked sum over the neighbours, one per column
    always_comb begin
        for (int c = 0; c < `GCN_FEAT_COLS; c++) begin
            acc[c] = '0;
            for (int n = 0; n < `GCN_NODES; n++) begin
                if (adj_row[n])
                    acc[c] = acc[c] + agg_sum_t'(feats[n][c]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++)
                sums[c] <= '0;
        end else if (clear) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++)
                sums[c] <= '0;
        end else if (capture) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++)
                sums[c] <= acc[c];  // row is stable by now
        end
    end

endmodule

// File: src/gcn_pkg.sv
`include "gcn_settings.svh"

package gcn_pkg;

    ///////////////////////////////
    // graph data
    ///////////////////////////////
    typedef logic [`GCN_ID_W-1:0]  node_id_t;     // 1..GCN_NODES names a node
    typedef logic [`GCN_NODES-1:0] node_mask_t;   // one adjacency row
    typedef logic [`GCN_FEAT_W-1:0] feat_t;
    typedef logic [`GCN_SUM_W-1:0] agg_sum_t;

    ///////////////////////////////
    // bus
    ///////////////////////////////
    typedef logic [`GCN_ADR_W-1:0] wb_adr_t;
    typedef logic [`GCN_DAT_W-1:0] wb_dat_t;

    // edge walker
    typedef enum logic [1:0] {
        st_idle,
        st_clear,       // zero matrix and sums
        st_walk,        // one edge per cycle
        st_capture      // aggregators load their sums
    } adj_state_t;

endpackage

// File: src/gcn_settings.svh
`ifndef GCN_SETTINGS_SVH
`define GCN_SETTINGS_SVH

// graph size
`define GCN_NODES       6
`define GCN_EDGES       6       // edge slots in coordinate form

// datapath widths
`define GCN_FEAT_W      5
`define GCN_FEAT_COLS   2
`define GCN_SUM_W       8       // six five-bit terms fit
`define GCN_ID_W        3       // id 0 is an empty slot

// wishbone
`define GCN_ADR_W       6       // word address
`define GCN_DAT_W       16

// register map, feature and sum words at base + cols*node + col
`define GCN_REG_CTRL    0
`define GCN_REG_EDGE    8
`define GCN_REG_FEAT    16
`define GCN_REG_SUM     32

`endif

// File: src/gcn_top.sv
`include "gcn_settings.svh"

module gcn_top
    import gcn_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat_w,
    output wb_dat_t wb_dat_r,
    output logic    wb_ack
);

    logic       start;
    logic       clear;
    logic       capture;
    logic       busy;
    node_id_t   edge_src [`GCN_EDGES];
    node_id_t   edge_dst [`GCN_EDGES];
    feat_t      feats [`GCN_NODES][`GCN_FEAT_COLS];
    node_mask_t adj_rows [`GCN_NODES];
    agg_sum_t   sums [`GCN_NODES][`GCN_FEAT_COLS];

    gcn_wb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .start    (start),
        .edge_src (edge_src),
        .edge_dst (edge_dst),
        .feats    (feats),
        .busy     (busy),
        .capture  (capture),
        .sums     (sums)
    );

    gcn_adj_builder u_adj (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .edge_src (edge_src),
        .edge_dst (edge_dst),
        .adj_rows (adj_rows),
        .clear    (clear),
        .capture  (capture),
        .busy     (busy)
    );

    // one aggregator per node
    for (genvar g = 0; g < `GCN_NODES; g++) begin : g_node
        gcn_node_agg u_agg (
            .clk     (clk),
            .rst_n   (rst_n),
            .clear   (clear),
            .capture (capture),
            .adj_row (adj_rows[g]),
            .feats   (feats),
            .sums    (sums[g])
        );
    end

endmodule

// File: src/gcn_wb_regs.sv
`include "gcn_settings.svh"

module gcn_wb_regs
    import gcn_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_adr_t  wb_adr,
    input  wb_dat_t  wb_dat_w,
    output wb_dat_t  wb_dat_r,
    output logic     wb_ack,
    output logic     start,
    output node_id_t edge_src [`GCN_EDGES],
    output node_id_t edge_dst [`GCN_EDGES],
    output feat_t    feats [`GCN_NODES][`GCN_FEAT_COLS],
    input  logic     busy,
    input  logic     capture,
    input  agg_sum_t sums [`GCN_NODES][`GCN_FEAT_COLS]
);

    logic    req;       // new access, ack not given yet
    logic    wr;        // write lands on the edge that ends the ack cycle
    logic    ctrl_sel;
    logic    done;
    wb_dat_t rd_data;

    assign req      = wb_cyc & wb_stb & ~wb_ack;
    assign wr       = wb_cyc & wb_stb & wb_we & wb_ack;
    assign ctrl_sel = (wb_adr == wb_adr_t'(`GCN_REG_CTRL));

    ///////////////////////////////
    // handshake, start and status
    ///////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            done   <= 1'b0;
        end else begin
            wb_ack <= req;      // single cycle, never stalls
            start  <= wr & ctrl_sel & wb_dat_w[0] & ~busy;
            if (start)
                done <= 1'b0;
            else if (capture)
                done <= 1'b1;   // sums are loaded on this same edge
        end
    end

    ///////////////////////////////
    // graph registers
    ///////////////////////////////

    // empty slots after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < `GCN_EDGES; e++) begin
                edge_src[e] <= '0;
                edge_dst[e] <= '0;
            end
        end else if (wr && !busy) begin
            for (int e = 0; e < `GCN_EDGES; e++) begin
                if (wb_adr == wb_adr_t'(`GCN_REG_EDGE + e)) begin
                    edge_src[e] <= wb_dat_w[`GCN_ID_W-1:0];
                    edge_dst[e] <= wb_dat_w[4 +: `GCN_ID_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !busy) begin
            for (int n = 0; n < `GCN_NODES; n++) begin
                for (int c = 0; c < `GCN_FEAT_COLS; c++) begin
                    if (wb_adr == wb_adr_t'(`GCN_REG_FEAT + `GCN_FEAT_COLS * n + c))
                        feats[n][c] <= wb_dat_w[`GCN_FEAT_W-1:0];
                end
            end
        end
    end

    ///////////////////////////////
    // read back
    ///////////////////////////////
    always_comb begin
        rd_data = '0;   // unmapped
        if (ctrl_sel)
            rd_data = wb_dat_t'({done, busy});
        for (int e = 0; e < `GCN_EDGES; e++) begin
            if (wb_adr == wb_adr_t'(`GCN_REG_EDGE + e))
                rd_data = wb_dat_t'({edge_dst[e], 1'b0, edge_src[e]});
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++) begin
                if (wb_adr == wb_adr_t'(`GCN_REG_FEAT + `GCN_FEAT_COLS * n + c))
                    rd_data = wb_dat_t'(feats[n][c]);
                if (wb_adr == wb_adr_t'(`GCN_REG_SUM + `GCN_FEAT_COLS * n + c))
                    rd_data = wb_dat_t'(sums[n][c]);   // zero-extended
            end
        end
    end

    // sampled with the request, valid while ack is high
    always_ff @(posedge clk) begin
        if (req)
            wb_dat_r <= rd_data;
    end

endmodule

// File: verif/gcn_chk.sv
`include "gcn_settings.svh"

module gcn_chk
    import gcn_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       start,
    input logic       capture,
    input node_mask_t adj_rows [`GCN_NODES]
);
    timeunit 1ns;
    timeprecision 100ps;

    logic rows_sym;

    // matrix must mirror across the diagonal
    always_comb begin
        rows_sym = 1'b1;
        for (int i = 0; i < `GCN_NODES; i++) begin
            for (int j = 0; j < `GCN_NODES; j++) begin
                if (adj_rows[i][j] != adj_rows[j][i])
                    rows_sym = 1'b0;
            end
        end
    end

    ///////////////////////////////
    // bus handshake
    ///////////////////////////////
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a cyc and stb request");

    ///////////////////////////////
    // edge walker
    ///////////////////////////////
    a_capture_delay: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##(`GCN_EDGES + 1) capture)
        else $error("capture not seen at the expected cycle after start");

    a_capture_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        capture |=> !capture)
        else $error("capture longer than one cycle");

    a_rows_sym: assert property (@(posedge clk) disable iff (!rst_n)
        capture |-> rows_sym)
        else $error("adjacency rows not symmetric at capture");

endmodule

bind gcn_top gcn_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .start    (start),
    .capture  (capture),
    .adj_rows (adj_rows)
);

// File: verif/gcn_clk_gen.sv
module gcn_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_ns = 20;    // 40 ns period

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(negedge clk);  // reset over the first three cycles
        rst_n = 1'b1;
    end

    always #half_ns clk = ~clk;

endmodule

// File: verif/gcn_tb.sv
`include "gcn_settings.svh"

module gcn_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_ns    = 40;
    localparam int rand_runs = 4;
    localparam int all_runs  = rand_runs + 5;  // reset check, ring, bad ids, two busy runs
    localparam int run_bound = 200;            // bus cycles for load, start, poll, read back
    localparam int ack_limit = 8;
    localparam int poll_max  = (`GCN_EDGES + 2) / 3 + 3;  // a status read spans three cycles

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;

    // model of what the testbench wrote
    int          src_m [`GCN_EDGES];
    int          dst_m [`GCN_EDGES];
    int          feat_m [`GCN_NODES][`GCN_FEAT_COLS];
    logic [31:0] lfsr_state = 32'h4d35;
    int          mismatches = 0;
    int          failures = 0;

    gcn_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    gcn_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    // expected sum from the edge list, ids outside 1..nodes are dropped
    function automatic int ref_sum(input int node, input int col);
        bit adj [`GCN_NODES][`GCN_NODES];
        int s;
        int d;
        int total;
        for (int i = 0; i < `GCN_NODES; i++) begin
            for (int j = 0; j < `GCN_NODES; j++)
                adj[i][j] = 1'b0;
        end
        for (int e = 0; e < `GCN_EDGES; e++) begin
            s = src_m[e];
            d = dst_m[e];
            if (s >= 1 && s <= `GCN_NODES && d >= 1 && d <= `GCN_NODES) begin
                adj[s-1][d-1] = 1'b1;
                adj[d-1][s-1] = 1'b1;
            end
        end
        total = 0;
        for (int n = 0; n < `GCN_NODES; n++) begin
            if (adj[node][n])
                total += feat_m[n][col];
        end
        return total;
    endfunction

    ///////////////////////////////
    // bus access
    ///////////////////////////////
    task automatic bus_cycle(input bit we, input int adr, input int wdat, output int rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr[5:0];
        wb_dat_w = wdat[15:0];
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ack_limit);
        assert (wb_ack) else begin
            $display("no ack from the DUT for address %0d at %0t", adr, $time);
            failures++;
        end
        rdat = wb_dat_r;
        @(negedge clk);     // held through the edge that ends the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input int adr, input int dat);
        int unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input int adr, output int dat);
        bus_cycle(1'b0, adr, 0, dat);
    endtask

    task automatic check_value(input string name, input int exp, input int got);
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            mismatches++;
        end
    endtask

    ///////////////////////////////
    // graph runs
    ///////////////////////////////
    task automatic load_graph();
        for (int e = 0; e < `GCN_EDGES; e++)
            wb_write(`GCN_REG_EDGE + e, (dst_m[e] << 4) | src_m[e]);
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++)
                wb_write(`GCN_REG_FEAT + `GCN_FEAT_COLS * n + c, feat_m[n][c]);
        end
    endtask

    task automatic start_graph();
        wb_write(`GCN_REG_CTRL, 1);
    endtask

    task automatic wait_done();
        int status;
        int polls;
        polls = 0;
        do begin
            wb_read(`GCN_REG_CTRL, status);
            polls++;
        end while (!status[1] && polls < poll_max);
        assert (status[1]) else begin
            $display("done bit not set within %0d status reads after start", poll_max);
            failures++;
        end
        check_value("status", 2, status);   // done, not busy
    endtask

    task automatic compare_sums();
        int got;
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++) begin
                wb_read(`GCN_REG_SUM + `GCN_FEAT_COLS * n + c, got);
                check_value($sformatf("sum[%0d][%0d]", n, c), ref_sum(n, c), got);
            end
        end
    endtask

    task automatic run_graph();
        load_graph();
        start_graph();
        wait_done();
        compare_sums();
    endtask

    task automatic random_graph();
        for (int e = 0; e < `GCN_EDGES; e++) begin
            src_m[e] = take_bits(3);    // 0 and 7 show up as dead slots
            dst_m[e] = take_bits(3);
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++)
                feat_m[n][c] = take_bits(`GCN_FEAT_W);
        end
    endtask

    initial begin
        int status;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int e = 0; e < `GCN_EDGES; e++) begin
            src_m[e] = 0;
            dst_m[e] = 0;
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++)
                feat_m[n][c] = 0;
        end
        @(posedge rst_n);

        // empty edge list gives zero sums
        wb_read(`GCN_REG_CTRL, status);
        check_value("status", 0, status);
        compare_sums();

        // ring 1-2-3-4-5-6-1
        for (int e = 0; e < `GCN_EDGES; e++) begin
            src_m[e] = e + 1;
            dst_m[e] = (e + 1) % `GCN_NODES + 1;
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_FEAT_COLS; c++)
                feat_m[n][c] = 3 * n + 7 * c + 1;
        end
        run_graph();

        // reversed duplicate, dead ids and a self loop on node 3
        src_m = '{1, 2, 0, 7, 5, 3};
        dst_m = '{2, 1, 3, 4, 0, 3};
        run_graph();

        // writes while busy must not reach this run or the next
        start_graph();
        wb_write(`GCN_REG_EDGE, (4 << 4) | 6);
        start_graph();
        wait_done();
        compare_sums();
        start_graph();
        wb_write(`GCN_REG_FEAT + 1, 31);
        wait_done();
        compare_sums();

        for (int r = 0; r < rand_runs; r++) begin
            random_graph();
            run_graph();
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog
    initial begin
        #((all_runs * run_bound + 10) * clk_ns);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule
